// ==== demo_defines.svh ====
// Fixed memory map of the demo system. Bases must be aligned to their region size
// Region sizes must be powers of two
`ifndef DEMO_DEFINES_SVH
`define DEMO_DEFINES_SVH

// RAM region, shrunk to 1 KiB at the original base
`define DEMO_RAM_BASE 32'h0010_0000
`define DEMO_RAM_BYTES 1024

// Peripheral regions, one 4 KiB window each
`define DEMO_GPIO_BASE 32'h8000_0000
`define DEMO_TIMER_BASE 32'h8000_2000
`define DEMO_PERIPH_BYTES 4096

// GPIO pin counts
`define DEMO_GPI_WIDTH 8
`define DEMO_GPO_WIDTH 16

// Word index widths inside a region, byte bits excluded
`define DEMO_RAM_IDX_W ($clog2(`DEMO_RAM_BYTES) - 2)
`define DEMO_REG_IDX_W ($clog2(`DEMO_PERIPH_BYTES) - 2)

// Bus word width
`define DEMO_BUS_WIDTH 32

// Output pins are written in whole bytes
`define DEMO_GPO_BYTES (`DEMO_GPO_WIDTH / 8)

// RAM depth in words
`define DEMO_RAM_WORDS (`DEMO_RAM_BYTES / 4)

// Register offsets within a peripheral window, as word indices
`define DEMO_REG0_IDX 0
`define DEMO_REG1_IDX 1

// Timer compare value after reset, keeps the interrupt low
`define DEMO_CMP_RESET 32'hFFFF_FFFF

`endif

// ==== demo_pkg.sv ====
// Shared types of the demo bus. Field widths follow the region sizes in the defines
`include "demo_defines.svh"

package demo_pkg;

  // Device picked by the address decoder
  typedef enum logic [1:0] {
    DEV_NONE,
    DEV_RAM,
    DEV_GPIO,
    DEV_TIMER
  } dev_sel_e;

  // One bus address, split either as RAM word index or as peripheral register
  typedef union packed {
    struct packed {
      logic [29-`DEMO_RAM_IDX_W:0] region;   // Compared against RAM base
      logic [`DEMO_RAM_IDX_W-1:0]  word_idx; // Word within the RAM
      logic [1:0]                  byte_off;
    } ram;
    struct packed {
      logic [29-`DEMO_REG_IDX_W:0] region;   // Compared against peripheral bases
      logic [`DEMO_REG_IDX_W-1:0]  reg_idx;  // Register word offset
      logic [1:0]                  byte_off;
    } periph;
  } bus_addr_u;

endpackage

// ==== bus_decoder.sv ====
// Single host, no grant stall. Every request is answered one cycle later
// Unmapped addresses answer with err and zero read data
`include "demo_defines.svh"

module bus_decoder import demo_pkg::*; (
  input  logic        clk_sys_i,
  input  logic        rst_sys_ni,
  input  logic        bus_req_i,
  input  logic        bus_we_i,
  input  logic [3:0]  bus_be_i,
  input  bus_addr_u   bus_addr_i,
  input  logic [31:0] bus_wdata_i,
  output logic        dev_we_o,
  output logic [3:0]  dev_be_o,
  output bus_addr_u   dev_addr_o,
  output logic [31:0] dev_wdata_o,
  output logic        ram_req_o,
  output logic        gpio_req_o,
  output logic        timer_req_o,
  input  logic [31:0] ram_rdata_i,
  input  logic [31:0] gpio_rdata_i,
  input  logic [31:0] timer_rdata_i,
  output logic        bus_rvalid_o,
  output logic [31:0] bus_rdata_o,
  output logic        bus_err_o
);

  localparam logic [31:0] RAM_BASE   = `DEMO_RAM_BASE;
  localparam logic [31:0] GPIO_BASE  = `DEMO_GPIO_BASE;
  localparam logic [31:0] TIMER_BASE = `DEMO_TIMER_BASE;

  logic     ram_hit;
  logic     gpio_hit;
  logic     timer_hit;
  dev_sel_e sel_d;
  dev_sel_e sel_q;
  logic     rvalid_q;

  // Region match on the upper address bits only
  assign ram_hit   = bus_addr_i.ram.region == RAM_BASE[31:`DEMO_RAM_IDX_W+2];
  assign gpio_hit  = bus_addr_i.periph.region == GPIO_BASE[31:`DEMO_REG_IDX_W+2];
  assign timer_hit = bus_addr_i.periph.region == TIMER_BASE[31:`DEMO_REG_IDX_W+2];

  always_comb begin
    sel_d = DEV_NONE;
    if (ram_hit) begin
      sel_d = DEV_RAM;
    end else if (gpio_hit) begin
      sel_d = DEV_GPIO;
    end else if (timer_hit) begin
      sel_d = DEV_TIMER;
    end
  end

  assign ram_req_o   = bus_req_i & (sel_d == DEV_RAM);
  assign gpio_req_o  = bus_req_i & (sel_d == DEV_GPIO);
  assign timer_req_o = bus_req_i & (sel_d == DEV_TIMER);

  // Shared request payload, only the strobes are per device
  assign dev_we_o    = bus_we_i;
  assign dev_be_o    = bus_be_i;
  assign dev_addr_o  = bus_addr_i;
  assign dev_wdata_o = bus_wdata_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
      sel_q    <= DEV_NONE;
    end else begin
      rvalid_q <= bus_req_i;
      sel_q    <= bus_req_i ? sel_d : DEV_NONE; // Idle cycles select nothing
    end
  end

  always_comb begin
    case (sel_q)
      DEV_RAM:   bus_rdata_o = ram_rdata_i;
      DEV_GPIO:  bus_rdata_o = gpio_rdata_i;
      DEV_TIMER: bus_rdata_o = timer_rdata_i;
      default:   bus_rdata_o = 32'h0;
    endcase
  end

  assign bus_rvalid_o = rvalid_q;
  assign bus_err_o    = rvalid_q & (sel_q == DEV_NONE);

endmodule

// ==== data_ram.sv ====
// 1 KiB word RAM, no init file. Contents are undefined until written
// Only the word index of the address is used, byte bits are ignored
`include "demo_defines.svh"

module data_ram import demo_pkg::*; (
  input  logic        clk_sys_i,
  input  logic        rst_sys_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  bus_addr_u   addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o
);

  logic [31:0] mem [`DEMO_RAM_WORDS];
  logic [`DEMO_RAM_IDX_W-1:0] idx;

  assign idx = addr_i.ram.word_idx;

  // Byte lanes written under their enables
  always_ff @(posedge clk_sys_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < 4; i++) begin
        if (be_i[i]) begin
          mem[idx][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
    end
  end

  // Read data one cycle after the request
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= 32'h0;
    end else if (req_i) begin
      if (we_i) begin
        rdata_o <= 32'h0; // Writes answer with zero
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

// ==== gpio_regs.sv ====
// Word 0 is the output register, word 1 the synchronized input pins
// Inputs show up in the readable register two cycles after they change
`include "demo_defines.svh"

module gpio_regs import demo_pkg::*; (
  input  logic                       clk_sys_i,
  input  logic                       rst_sys_ni,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [3:0]                 be_i,
  input  bus_addr_u                  addr_i,
  input  logic [31:0]                wdata_i,
  input  logic [`DEMO_GPI_WIDTH-1:0] gp_i,
  output logic [31:0]                rdata_o,
  output logic [`DEMO_GPO_WIDTH-1:0] gp_o
);

  logic [`DEMO_GPI_WIDTH-1:0] gp_meta_q;
  logic [`DEMO_GPI_WIDTH-1:0] gp_in_q;
  logic                       out_sel;
  logic                       in_sel;

  assign out_sel = addr_i.periph.reg_idx == `DEMO_REG0_IDX;
  assign in_sel  = addr_i.periph.reg_idx == `DEMO_REG1_IDX;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o      <= '0;
      gp_meta_q <= '0;
      gp_in_q   <= '0;
    end else begin
      gp_meta_q <= gp_i; // Two-flop synchronizer
      gp_in_q   <= gp_meta_q;
      if (req_i && we_i && out_sel) begin
        for (int i = 0; i < `DEMO_GPO_BYTES; i++) begin
          if (be_i[i]) begin
            gp_o[8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= 32'h0;
    end else if (req_i) begin
      if (!we_i && out_sel) begin
        rdata_o <= {{(32-`DEMO_GPO_WIDTH){1'b0}}, gp_o};
      end else if (!we_i && in_sel) begin
        rdata_o <= {{(32-`DEMO_GPI_WIDTH){1'b0}}, gp_in_q};
      end else begin
        rdata_o <= 32'h0; // Writes and unused offsets
      end
    end
  end

endmodule

// ==== timer_regs.sv ====
// Word 0 is a free-running 32-bit counter, word 1 the compare value
// Interrupt is a level, high while counter >= compare, one cycle behind the values
`include "demo_defines.svh"

module timer_regs import demo_pkg::*; (
  input  logic        clk_sys_i,
  input  logic        rst_sys_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  bus_addr_u   addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        timer_irq_o
);

  logic [31:0] mtime_q;
  logic [31:0] mtime_d;
  logic [31:0] cmp_q;
  logic        time_sel;
  logic        cmp_sel;
  logic        time_we;
  logic        cmp_we;

  // Replace the enabled byte lanes of a register
  function automatic logic [31:0] merge_be(input logic [31:0] old_w,
                                           input logic [31:0] new_w,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign time_sel = addr_i.periph.reg_idx == `DEMO_REG0_IDX;
  assign cmp_sel  = addr_i.periph.reg_idx == `DEMO_REG1_IDX;
  assign time_we  = req_i & we_i & time_sel;
  assign cmp_we   = req_i & we_i & cmp_sel;

  // A write loads the counter, counting resumes on the next cycle
  assign mtime_d = time_we ? merge_be(mtime_q, wdata_i, be_i) : mtime_q + 32'd1;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q     <= 32'h0;
      cmp_q       <= `DEMO_CMP_RESET;
      timer_irq_o <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      timer_irq_o <= mtime_q >= cmp_q; // Compares the current values
      if (cmp_we) begin
        cmp_q <= merge_be(cmp_q, wdata_i, be_i);
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= 32'h0;
    end else if (req_i) begin
      if (!we_i && time_sel) begin
        rdata_o <= mtime_q; // Value at the request edge
      end else if (!we_i && cmp_sel) begin
        rdata_o <= cmp_q;
      end else begin
        rdata_o <= 32'h0;
      end
    end
  end

endmodule

// ==== demo_system.sv ====
// Peripheral side of the demo system, driven by one host on the data bus
// Requests are single-cycle strobes, each answered by rvalid one cycle later
`include "demo_defines.svh"

module demo_system import demo_pkg::*; (
  input  logic                       clk_sys_i,
  input  logic                       rst_sys_ni,
  input  logic                       bus_req_i,
  input  logic                       bus_we_i,
  input  logic [3:0]                 bus_be_i,
  input  logic [31:0]                bus_addr_i,
  input  logic [31:0]                bus_wdata_i,
  output logic                       bus_rvalid_o,
  output logic [31:0]                bus_rdata_o,
  output logic                       bus_err_o,
  input  logic [`DEMO_GPI_WIDTH-1:0] gp_i,
  output logic [`DEMO_GPO_WIDTH-1:0] gp_o,
  output logic                       timer_irq_o
);

  // Shared device request payload
  logic        dev_we;
  logic [3:0]  dev_be;
  bus_addr_u   dev_addr;
  logic [31:0] dev_wdata;

  logic        ram_req;
  logic        gpio_req;
  logic        timer_req;
  logic [31:0] ram_rdata;
  logic [31:0] gpio_rdata;
  logic [31:0] timer_rdata;

  bus_decoder u_decoder (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .bus_req_i     (bus_req_i),
    .bus_we_i      (bus_we_i),
    .bus_be_i      (bus_be_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_addr_o    (dev_addr),
    .dev_wdata_o   (dev_wdata),
    .ram_req_o     (ram_req),
    .gpio_req_o    (gpio_req),
    .timer_req_o   (timer_req),
    .ram_rdata_i   (ram_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata),
    .bus_rvalid_o  (bus_rvalid_o),
    .bus_rdata_o   (bus_rdata_o),
    .bus_err_o     (bus_err_o)
  );

  data_ram u_ram (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (ram_req),
    .we_i       (dev_we),
    .be_i       (dev_be),
    .addr_i     (dev_addr),
    .wdata_i    (dev_wdata),
    .rdata_o    (ram_rdata)
  );

  gpio_regs u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (gpio_req),
    .we_i       (dev_we),
    .be_i       (dev_be),
    .addr_i     (dev_addr),
    .wdata_i    (dev_wdata),
    .gp_i       (gp_i),
    .rdata_o    (gpio_rdata),
    .gp_o       (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .req_i       (timer_req),
    .we_i        (dev_we),
    .be_i        (dev_be),
    .addr_i      (dev_addr),
    .wdata_i     (dev_wdata),
    .rdata_o     (timer_rdata),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// ==== tb_bus_checker.sv ====
// Watches the bus responses of demo_system and compares them with queued expectations
// Samples on the falling edge, where all DUT outputs have settled
`include "demo_defines.svh"

module tb_bus_checker (
  input logic                       clk_sys_i,
  input logic                       bus_req_i,
  input logic                       bus_rvalid_i,
  input logic [31:0]                bus_rdata_i,
  input logic                       bus_err_i,
  input logic                       timer_irq_i,
  input logic [`DEMO_GPO_WIDTH-1:0] gpo_i
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [7:0]                 test;
    logic [31:0]                rdata;
    logic                       err;
    logic                       irq;
    logic [`DEMO_GPO_WIDTH-1:0] gpo;
  } resp_t;

  resp_t exp_q[$];
  resp_t cur;
  int    err_cnt    = 0;
  int    resp_cnt   = 0;
  int    test_cnt   = 0;
  int    cur_test   = -1;
  int    test_errs  = 0;
  int    test_resps = 0;
  logic  req_q      = 1'b0; // Request strobe of the previous cycle

  task automatic add_expect(input int test, input logic [31:0] rdata, input logic err,
                            input logic irq, input logic [`DEMO_GPO_WIDTH-1:0] gpo);
    exp_q.push_back({test[7:0], rdata, err, irq, gpo});
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    err_cnt++;
    test_errs++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_error($sformatf("FAIL test %0d %s: got 0x%h, expected 0x%h",
                             cur_test, name, got, exp));
    end
  endtask

  // One line for the test that just ended
  task automatic close_test();
    if (cur_test >= 0) begin
      $display("Test %0d done: %0d responses, %0d errors", cur_test, test_resps, test_errs);
      test_cnt++;
    end
    test_errs  = 0;
    test_resps = 0;
  endtask

  always @(negedge clk_sys_i) begin
    if (bus_rvalid_i === 1'b1 && !req_q) begin
      report_error($sformatf("Test %0d: rvalid came without a request one cycle earlier",
                             cur_test));
    end else if (bus_rvalid_i !== 1'b1 && req_q) begin
      report_error($sformatf("Test %0d: a request got no rvalid one cycle later", cur_test));
    end
    if (bus_rvalid_i === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_error("An rvalid arrived with no expected response pending");
      end else begin
        cur = exp_q.pop_front();
        if (cur.test != cur_test) begin
          close_test();
          cur_test = cur.test;
        end
        resp_cnt++;
        test_resps++;
        check_value("bus_rdata_o", bus_rdata_i, cur.rdata);
        check_value("bus_err_o", bus_err_i, cur.err);
        check_value("timer_irq_o", timer_irq_i, cur.irq);
        check_value("gp_o", gpo_i, cur.gpo);
      end
    end
    req_q = (bus_req_i === 1'b1);
  end

  task automatic finish_report();
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d expected responses never arrived", exp_q.size()));
    end
    if (resp_cnt == 0) begin
      report_error("No responses were checked, the access list may be missing");
    end
    close_test();
    $display("Tests: %0d, responses: %0d, errors: %0d", test_cnt, resp_cnt, err_cnt);
  endtask

endmodule

// ==== tb_demo_system.sv ====
// Testbench for demo_system, run from the project root so demo_stim.txt is found
// One access line is driven per rising edge, tb_bus_checker does the comparing
`include "demo_defines.svh"

module tb_demo_system;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int STIM_COLS = 11; // Words per access line
  localparam int MAX_LINES = 64;

  logic                       clk_sys = 1'b0;
  logic                       rst_sys_n;
  logic                       bus_req;
  logic                       bus_we;
  logic [3:0]                 bus_be;
  logic [31:0]                bus_addr;
  logic [31:0]                bus_wdata;
  logic                       bus_rvalid;
  logic [31:0]                bus_rdata;
  logic                       bus_err;
  logic [`DEMO_GPI_WIDTH-1:0] gp_in;
  logic [`DEMO_GPO_WIDTH-1:0] gp_out;
  logic                       timer_irq;

  logic [31:0] stim_words [MAX_LINES*STIM_COLS];
  int          n_lines     = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          guard;

  always #5 clk_sys = ~clk_sys;

  demo_system dut_i (
    .clk_sys_i    (clk_sys),
    .rst_sys_ni   (rst_sys_n),
    .bus_req_i    (bus_req),
    .bus_we_i     (bus_we),
    .bus_be_i     (bus_be),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata),
    .bus_err_o    (bus_err),
    .gp_i         (gp_in),
    .gp_o         (gp_out),
    .timer_irq_o  (timer_irq)
  );

  tb_bus_checker u_checker (
    .clk_sys_i    (clk_sys),
    .bus_req_i    (bus_req),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata),
    .bus_err_i    (bus_err),
    .timer_irq_i  (timer_irq),
    .gpo_i        (gp_out)
  );

  // Drives one access line and queues its expected response
  task automatic drive_line(input int n);
    int b;
    b = STIM_COLS * n;
    bus_req   <= stim_words[b+1][0];
    bus_we    <= stim_words[b+2][0];
    bus_be    <= stim_words[b+3][3:0];
    bus_addr  <= stim_words[b+4];
    bus_wdata <= stim_words[b+5];
    gp_in     <= stim_words[b+6][`DEMO_GPI_WIDTH-1:0];
    if (stim_words[b+1][0]) begin
      u_checker.add_expect(stim_words[b], stim_words[b+7], stim_words[b+8][0],
                           stim_words[b+9][0], stim_words[b+10][`DEMO_GPO_WIDTH-1:0]);
    end
  endtask

  initial begin
    rst_sys_n = 1'b0;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_be    = 4'h0;
    bus_addr  = 32'h0;
    bus_wdata = 32'h0;
    gp_in     = '0;
    $readmemh("demo_stim.txt", stim_words);
    // Test numbers start at 1, so a zero or unknown word ends the list
    while (n_lines < MAX_LINES && !$isunknown(stim_words[STIM_COLS*n_lines]) &&
           stim_words[STIM_COLS*n_lines] != 0) begin
      n_lines++;
    end
    cycle_limit = n_lines * 2 + 8 + 50;
    repeat (8) @(posedge clk_sys);
    rst_sys_n <= 1'b1;
    for (int i = 0; i < n_lines; i++) begin
      @(posedge clk_sys);
      drive_line(i);
    end
    @(posedge clk_sys);
    bus_req <= 1'b0;
    guard = 0;
    while (u_checker.pending() != 0 && guard < 4) begin // Last response in flight
      @(posedge clk_sys);
      guard++;
    end
    u_checker.finish_report();
    if (u_checker.err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge clk_sys) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

// ==== demo_stim.txt ====
// test req we be addr wdata gp_i exp_rdata exp_err exp_irq exp_gp_o, all hex
// Lines with req 0 are idle cycles and their expected columns are ignored
1 1 1 f 00100000 11223344 00 00000000 0 0 0000
1 1 1 f 001003fc deadbeef 00 00000000 0 0 0000
1 1 0 f 00100000 00000000 00 11223344 0 0 0000
1 1 0 f 001003fc 00000000 00 deadbeef 0 0 0000
1 1 1 f 00100100 0badf00d 00 00000000 0 0 0000
1 1 0 f 00100100 00000000 00 0badf00d 0 0 0000
2 1 1 3 00100100 12345678 00 00000000 0 0 0000
2 1 0 f 00100100 00000000 00 0bad5678 0 0 0000
2 1 1 8 00100000 ff000000 00 00000000 0 0 0000
2 1 0 f 00100000 00000000 00 ff223344 0 0 0000
3 1 1 f 80000000 0000beef 5a 00000000 0 0 beef
3 1 0 f 80000000 00000000 5a 0000beef 0 0 beef
3 0 0 0 00000000 00000000 5a 00000000 0 0 beef
3 0 0 0 00000000 00000000 5a 00000000 0 0 beef
3 0 0 0 00000000 00000000 5a 00000000 0 0 beef
3 1 0 f 80000004 00000000 5a 0000005a 0 0 beef
4 1 0 f 40000000 00000000 5a 00000000 1 0 beef
4 1 1 f 00100400 12345678 5a 00000000 1 0 beef
5 1 1 f 80002004 ffffffff 5a 00000000 0 0 beef
5 1 1 f 80002000 00000000 5a 00000000 0 0 beef
5 0 0 0 00000000 00000000 5a 00000000 0 0 beef
5 0 0 0 00000000 00000000 5a 00000000 0 0 beef
5 1 0 f 80002000 00000000 5a 00000002 0 0 beef
5 1 0 f 80002000 00000000 5a 00000003 0 0 beef
5 1 1 f 80002004 00000002 5a 00000000 0 0 beef
5 1 0 f 80002004 00000000 5a 00000002 0 1 beef
5 1 1 f 80002004 ffffffff 5a 00000000 0 1 beef
5 1 0 f 80002004 00000000 5a ffffffff 0 0 beef
5 1 0 f 80002000 00000000 5a 00000008 0 0 beef

// ==== filelist.f ====
+incdir+.
demo_pkg.sv
bus_decoder.sv
data_ram.sv
gpio_regs.sv
timer_regs.sv
demo_system.sv
tb_bus_checker.sv
tb_demo_system.sv
